// ==== hdl/conv_pkg.sv ====
package conv_pkg;

	// bus data word of the external memory
	localparam int WORD_W = 16;

	// taps of a 3x3 kernel, k = ky*3 + kx
	localparam int KERNEL_TAPS = 9;

	typedef logic [WORD_W-1:0] word_t;

	// image pixels are unsigned, coefficients signed
	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// result wraps on overflow
	typedef logic signed [15:0] acc_t;

	// row or column index
	typedef logic [7:0] pos_t;

endpackage

// ==== hdl/mem_map_pkg.sv ====
package mem_map_pkg;

	typedef logic [7:0] addr_t;

	// weight for channel ch, tap k at WEIGHT_BASE + ch*9 + k
	localparam addr_t WEIGHT_BASE = 8'd0;

	// one bias word per channel
	localparam addr_t BIAS_BASE = 8'd64;

	// image stored row-major
	localparam addr_t PIXEL_BASE = 8'd128;

endpackage

// ==== hdl/mem_wb_if.sv ====
interface mem_wb_if;

	logic cyc;
	logic stb;
	mem_map_pkg::addr_t adr;
	conv_pkg::word_t dat;
	logic ack;

	// read-only bus, so dat only flows toward the master
	modport master (
		output cyc,
		output stb,
		output adr,
		input dat,
		input ack
	);

	modport slave (
		input cyc,
		input stb,
		input adr,
		output dat,
		output ack
	);

endinterface

// ==== hdl/mem_arbiter.sv ====
module mem_arbiter (
	input logic clk,
	input logic rst,
	mem_wb_if.slave weight_bus,
	mem_wb_if.slave bias_bus,
	mem_wb_if.slave pixel_bus,
	mem_wb_if.master mem_bus
);

	// one-hot grant, bit 0 weight, bit 1 bias, bit 2 pixel
	logic [2:0] grant;
	logic [2:0] grant_next;
	logic [2:0] req;
	logic [2:0] strobe;

	always_comb
	begin
		req = {pixel_bus.cyc, bias_bus.cyc, weight_bus.cyc};
		strobe = {pixel_bus.stb, bias_bus.stb, weight_bus.stb};
		if (|(grant & req))
			grant_next = grant;
		else if (req[0])
			grant_next = 3'b001;
		else if (req[1])
			grant_next = 3'b010;
		else if (req[2])
			grant_next = 3'b100;
		else
			grant_next = 3'b000;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			grant <= 3'b000;
		else
			grant <= grant_next;
	end

	assign mem_bus.cyc = |(grant & req);
	assign mem_bus.stb = |(grant & strobe);

	always_comb
	begin
		if (grant[0])
			mem_bus.adr = weight_bus.adr;
		else if (grant[1])
			mem_bus.adr = bias_bus.adr;
		else if (grant[2])
			mem_bus.adr = pixel_bus.adr;
		else
			mem_bus.adr = '0;
	end

	// return path only to the owner of the bus
	assign weight_bus.ack = grant[0] & mem_bus.ack;
	assign bias_bus.ack = grant[1] & mem_bus.ack;
	assign pixel_bus.ack = grant[2] & mem_bus.ack;
	assign weight_bus.dat = grant[0] ? mem_bus.dat : '0;
	assign bias_bus.dat = grant[1] ? mem_bus.dat : '0;
	assign pixel_bus.dat = grant[2] ? mem_bus.dat : '0;

endmodule

// ==== hdl/coef_loader.sv ====
module coef_loader #(
	parameter type coef_t = conv_pkg::weight_t,
	parameter int COUNT = 36,
	parameter mem_map_pkg::addr_t BASE = mem_map_pkg::WEIGHT_BASE
) (
	input logic clk,
	input logic rst,
	input logic start,
	mem_wb_if.master bus,
	output coef_t coefs [COUNT],
	output logic loaded
);

	logic busy;
	mem_map_pkg::addr_t idx;

	assign bus.cyc = busy;
	assign bus.stb = busy;
	assign bus.adr = BASE + idx;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			loaded <= 1'b0;
			idx <= '0;
		end
		else if (start && !busy)
		begin
			busy <= 1'b1;
			loaded <= 1'b0;
			idx <= '0;
		end
		else if (busy && bus.ack)
		begin
			if (idx == mem_map_pkg::addr_t'(COUNT - 1))
			begin
				busy <= 1'b0;
				loaded <= 1'b1;
			end
			else
				idx <= idx + 1'b1;
		end
	end

	// words enter at the top, so the first one settles at index 0
	always_ff @(posedge clk)
	begin
		if (busy && bus.ack)
		begin
			for (int i = 0; i < COUNT - 1; i++)
				coefs[i] <= coefs[i + 1];
			coefs[COUNT - 1] <= coef_t'(bus.dat[$bits(coef_t) - 1:0]);
		end
	end

endmodule

// ==== hdl/pixel_fetcher.sv ====
module pixel_fetcher #(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic coefs_ready,
	mem_wb_if.master bus,
	output logic pix_valid,
	output conv_pkg::pixel_t pix
);

	localparam mem_map_pkg::addr_t LAST_IDX = mem_map_pkg::addr_t'(IMG_W * IMG_H - 1);

	typedef enum logic [1:0] {
		IDLE,
		ARMED,
		FETCH
	} state_t;

	state_t state;
	mem_map_pkg::addr_t idx;

	assign bus.cyc = (state == FETCH);
	assign bus.stb = (state == FETCH);
	assign bus.adr = mem_map_pkg::PIXEL_BASE + idx;

	// pixel goes out in the ack cycle itself
	assign pix_valid = (state == FETCH) && bus.ack;
	assign pix = bus.dat[$bits(conv_pkg::pixel_t) - 1:0];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= IDLE;
			idx <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
						state <= ARMED;
				end
				ARMED:
				begin
					idx <= '0;
					if (coefs_ready)
						state <= FETCH;
				end
				FETCH:
				begin
					if (bus.ack)
					begin
						if (idx == LAST_IDX)
							state <= IDLE;
						else
							idx <= idx + 1'b1;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/line_window.sv ====
module line_window #(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6
) (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input conv_pkg::pixel_t pix,
	output conv_pkg::pixel_t window [conv_pkg::KERNEL_TAPS],
	output logic win_valid,
	output conv_pkg::pos_t win_row,
	output conv_pkg::pos_t win_col,
	output logic win_last
);

	conv_pkg::pixel_t line1 [IMG_W];
	conv_pkg::pixel_t line2 [IMG_W];
	conv_pkg::pixel_t column [3];
	conv_pkg::pos_t row;
	conv_pkg::pos_t col;

	// new window column, top to bottom
	always_comb
	begin
		column[0] = line2[IMG_W - 1];
		column[1] = line1[IMG_W - 1];
		column[2] = pix;
	end

	// each buffer delays the stream by one image row
	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			line1[0] <= pix;
			line2[0] <= line1[IMG_W - 1];
			for (int i = 1; i < IMG_W; i++)
			begin
				line1[i] <= line1[i - 1];
				line2[i] <= line2[i - 1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			for (int ky = 0; ky < 3; ky++)
			begin
				window[ky * 3] <= window[ky * 3 + 1];
				window[ky * 3 + 1] <= window[ky * 3 + 2];
				window[ky * 3 + 2] <= column[ky];
			end
		end
	end

	// position of the incoming pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			row <= '0;
			col <= '0;
		end
		else if (pix_valid)
		begin
			if (col == conv_pkg::pos_t'(IMG_W - 1))
			begin
				col <= '0;
				if (row == conv_pkg::pos_t'(IMG_H - 1))
					row <= '0;
				else
					row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end
		else
		begin
			win_valid <= pix_valid && (row >= 2) && (col >= 2);
			win_last <= pix_valid && (row == conv_pkg::pos_t'(IMG_H - 1))
				&& (col == conv_pkg::pos_t'(IMG_W - 1));
		end
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			win_row <= row - 2'd2;
			win_col <= col - 2'd2;
		end
	end

endmodule

// ==== hdl/conv_mac.sv ====
module conv_mac #(
	parameter int OUT_CH = 4
) (
	input logic clk,
	input logic rst,
	input logic win_valid,
	input conv_pkg::pos_t win_row,
	input conv_pkg::pos_t win_col,
	input logic win_last,
	input conv_pkg::pixel_t window [conv_pkg::KERNEL_TAPS],
	input conv_pkg::weight_t weights [OUT_CH * conv_pkg::KERNEL_TAPS],
	input conv_pkg::bias_t biases [OUT_CH],
	output logic out_valid,
	output conv_pkg::pos_t out_row,
	output conv_pkg::pos_t out_col,
	output conv_pkg::acc_t [OUT_CH-1:0] out_data,
	output logic done
);

	conv_pkg::acc_t prod [OUT_CH][conv_pkg::KERNEL_TAPS];
	conv_pkg::acc_t sum [OUT_CH];

	// all arithmetic modulo 2^16, so truncation comes for free
	always_comb
	begin
		for (int ch = 0; ch < OUT_CH; ch++)
		begin
			for (int k = 0; k < conv_pkg::KERNEL_TAPS; k++)
				prod[ch][k] = conv_pkg::acc_t'(window[k])
					* conv_pkg::acc_t'(weights[ch * conv_pkg::KERNEL_TAPS + k]);
			sum[ch] = ((prod[ch][0] + prod[ch][1]) + (prod[ch][2] + prod[ch][3]))
				+ ((prod[ch][4] + prod[ch][5]) + (prod[ch][6] + prod[ch][7]))
				+ (prod[ch][8] + biases[ch]);
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			out_valid <= win_valid;
			done <= win_valid && win_last;
		end
	end

	always_ff @(posedge clk)
	begin
		if (win_valid)
		begin
			out_row <= win_row;
			out_col <= win_col;
			for (int ch = 0; ch < OUT_CH; ch++)
				out_data[ch] <= sum[ch];
		end
	end

endmodule

// ==== hdl/conv_layer_top.sv ====
module conv_layer_top #(
	parameter int IMG_W = 8,
	parameter int IMG_H = 6,
	parameter int OUT_CH = 4
) (
	input logic clk,
	input logic rst,
	input logic start,
	output logic wb_cyc,
	output logic wb_stb,
	output mem_map_pkg::addr_t wb_adr,
	input conv_pkg::word_t wb_dat,
	input logic wb_ack,
	output logic out_valid,
	output conv_pkg::pos_t out_row,
	output conv_pkg::pos_t out_col,
	output conv_pkg::acc_t [OUT_CH-1:0] out_data,
	output logic done
);

	localparam int N_WEIGHTS = OUT_CH * conv_pkg::KERNEL_TAPS;

	mem_wb_if weight_bus ();
	mem_wb_if bias_bus ();
	mem_wb_if pixel_bus ();
	mem_wb_if mem_bus ();

	conv_pkg::weight_t weights [N_WEIGHTS];
	conv_pkg::bias_t biases [OUT_CH];
	logic weights_loaded;
	logic biases_loaded;
	logic pix_valid;
	conv_pkg::pixel_t pix;
	conv_pkg::pixel_t window [conv_pkg::KERNEL_TAPS];
	logic win_valid;
	conv_pkg::pos_t win_row;
	conv_pkg::pos_t win_col;
	logic win_last;

	assign wb_cyc = mem_bus.cyc;
	assign wb_stb = mem_bus.stb;
	assign wb_adr = mem_bus.adr;
	assign mem_bus.dat = wb_dat;
	assign mem_bus.ack = wb_ack;

	mem_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.weight_bus(weight_bus.slave),
		.bias_bus(bias_bus.slave),
		.pixel_bus(pixel_bus.slave),
		.mem_bus(mem_bus.master)
	);

	coef_loader #(
		.coef_t(conv_pkg::weight_t),
		.COUNT(N_WEIGHTS),
		.BASE(mem_map_pkg::WEIGHT_BASE)
	) u_weight_loader (
		.clk(clk),
		.rst(rst),
		.start(start),
		.bus(weight_bus.master),
		.coefs(weights),
		.loaded(weights_loaded)
	);

	coef_loader #(
		.coef_t(conv_pkg::bias_t),
		.COUNT(OUT_CH),
		.BASE(mem_map_pkg::BIAS_BASE)
	) u_bias_loader (
		.clk(clk),
		.rst(rst),
		.start(start),
		.bus(bias_bus.master),
		.coefs(biases),
		.loaded(biases_loaded)
	);

	pixel_fetcher #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_fetcher (
		.clk(clk),
		.rst(rst),
		.start(start),
		.coefs_ready(weights_loaded & biases_loaded),
		.bus(pixel_bus.master),
		.pix_valid(pix_valid),
		.pix(pix)
	);

	line_window #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_window (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix(pix),
		.window(window),
		.win_valid(win_valid),
		.win_row(win_row),
		.win_col(win_col),
		.win_last(win_last)
	);

	conv_mac #(
		.OUT_CH(OUT_CH)
	) u_mac (
		.clk(clk),
		.rst(rst),
		.win_valid(win_valid),
		.win_row(win_row),
		.win_col(win_col),
		.win_last(win_last),
		.window(window),
		.weights(weights),
		.biases(biases),
		.out_valid(out_valid),
		.out_row(out_row),
		.out_col(out_col),
		.out_data(out_data),
		.done(done)
	);

endmodule

// ==== testbench/tb_mem_model.sv ====
module tb_mem_model #(
	parameter int SEED = 1
) (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input mem_map_pkg::addr_t adr,
	output conv_pkg::word_t dat,
	output logic ack
);

	timeunit 1ns;
	timeprecision 100ps;

	// whole address space, filled from the testbench
	conv_pkg::word_t mem [256];

	integer wait_seed = SEED;
	int unsigned waits;

	// ack and data move on the falling edge
	always @(negedge clk or posedge rst)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			dat <= '0;
			waits <= 0;
		end
		else if (ack)
		begin
			ack <= 1'b0;
			// 0 to 3 wait states before the next ack
			waits <= $unsigned($random(wait_seed)) % 4;
		end
		else if (cyc && stb)
		begin
			if (waits == 0)
			begin
				ack <= 1'b1;
				dat <= mem[adr];
			end
			else
				waits <= waits - 1;
		end
	end

endmodule

// ==== testbench/tb_conv_layer.sv ====
module tb_conv_layer;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMG_W = 8;
	localparam int IMG_H = 6;
	localparam int OUT_CH = 4;
	localparam int OUT_W = IMG_W - 2;
	localparam int OUT_H = IMG_H - 2;
	localparam int COEF_WORDS = OUT_CH * 10;
	localparam int READS = COEF_WORDS + IMG_W * IMG_H;
	// 2 runs of READS reads at up to 5 cycles each, plus generous margin
	localparam int MAX_CYCLES = 2 * READS * 5 + 2120;

	logic clk;
	logic rst;
	logic start;
	logic wb_cyc;
	logic wb_stb;
	mem_map_pkg::addr_t wb_adr;
	conv_pkg::word_t wb_dat;
	logic wb_ack;
	logic out_valid;
	conv_pkg::pos_t out_row;
	conv_pkg::pos_t out_col;
	conv_pkg::acc_t [OUT_CH-1:0] out_data;
	logic done;

	integer seed = 32'h1dda_e681;
	int cycles = 0;
	int run_count = 0;
	int runs_done = 0;
	int coef_acks = 0;
	int exp_row = 0;
	int exp_col = 0;
	logic seen_start = 1'b0;
	logic bus_cyc = 1'b0;
	logic bus_stb = 1'b0;
	mem_map_pkg::addr_t bus_adr = '0;
	logic pending = 1'b0;
	mem_map_pkg::addr_t pending_adr = '0;
	// acks of window-completing pixels, two cycles deep
	logic [1:0] valid_due = '0;

	conv_layer_top #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H),
		.OUT_CH(OUT_CH)
	) DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.out_valid(out_valid),
		.out_row(out_row),
		.out_col(out_col),
		.out_data(out_data),
		.done(done)
	);

	tb_mem_model #(
		.SEED(32'h1dda_e681)
	) u_mem (
		.clk(clk),
		.rst(rst),
		.cyc(wb_cyc),
		.stb(wb_stb),
		.adr(wb_adr),
		.dat(wb_dat),
		.ack(wb_ack)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic fill_memory();
		for (int a = 0; a < 256; a++)
			u_mem.mem[a] = conv_pkg::word_t'($random(seed));
	endtask

	function automatic logic is_coef_addr(input mem_map_pkg::addr_t a);
		return (int'(a) < OUT_CH * 9) || (int'(a) >= 64 && int'(a) < 64 + OUT_CH);
	endfunction

	function automatic logic is_pixel_addr(input mem_map_pkg::addr_t a);
		return int'(a) >= 128 && int'(a) < 128 + IMG_W * IMG_H;
	endfunction

	// pixel at row and column both at least 2
	function automatic logic completes_window(input mem_map_pkg::addr_t a);
		int p;
		p = int'(a) - 128;
		return is_pixel_addr(a) && (p / IMG_W >= 2) && (p % IMG_W >= 2);
	endfunction

	// bias plus nine products, wrapped to 16 bits
	function automatic conv_pkg::acc_t expected_result(input int row, input int col, input int ch);
		int acc;
		int pixel;
		int weight;
		acc = int'($signed(u_mem.mem[64 + ch]));
		for (int ky = 0; ky < 3; ky++)
		begin
			for (int kx = 0; kx < 3; kx++)
			begin
				pixel = int'(u_mem.mem[128 + (row + ky) * IMG_W + col + kx][7:0]);
				weight = int'($signed(u_mem.mem[ch * 9 + ky * 3 + kx][7:0]));
				acc = acc + pixel * weight;
			end
		end
		return acc[15:0];
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			abort_run($sformatf("timeout after %0d cycles without the end of the test", cycles));
	end

	// bus view from the falling edge, checked against the ack at the rising edge
	always @(posedge clk)
	begin
		if (!rst)
		begin
			assert (!bus_stb || bus_cyc)
			else abort_run($sformatf("ERR wb_stb=%0h with wb_cyc=%0h", bus_stb, bus_cyc));
			if (pending)
				assert (bus_cyc && bus_stb && bus_adr == pending_adr)
				else abort_run($sformatf("ERR wb_adr=%0h wb_stb=%0h before ack, expected wb_adr=%0h",
					bus_adr, bus_stb, pending_adr));
			if (bus_stb)
			begin
				assert (is_coef_addr(bus_adr) || is_pixel_addr(bus_adr))
				else abort_run($sformatf("ERR wb_adr=%0h outside the memory map", bus_adr));
				if (is_pixel_addr(bus_adr))
					assert (coef_acks == run_count * COEF_WORDS)
					else abort_run($sformatf("ERR wb_adr=%0h pixel read after %0h coefficient acks",
						bus_adr, coef_acks));
				if (wb_ack && is_coef_addr(bus_adr))
					coef_acks++;
			end
			valid_due = {valid_due[0], bus_stb && wb_ack && completes_window(bus_adr)};
			pending = bus_stb && !wb_ack;
			pending_adr = bus_adr;
			if (start)
			begin
				seen_start = 1'b1;
				run_count++;
			end
		end
	end

	always @(negedge clk)
	begin
		bus_cyc = wb_cyc;
		bus_stb = wb_stb;
		bus_adr = wb_adr;
		if (!rst && !seen_start)
			assert (!wb_cyc && !wb_stb && !out_valid && !done)
			else abort_run($sformatf("ERR before start wb_cyc=%0h wb_stb=%0h out_valid=%0h done=%0h",
				wb_cyc, wb_stb, out_valid, done));
		assert (out_valid == valid_due[1])
		else abort_run($sformatf("ERR out_valid=%0h expected %0h two cycles after pixel ack",
			out_valid, valid_due[1]));
		if (out_valid)
		begin
			assert (int'(out_row) == exp_row && int'(out_col) == exp_col)
			else abort_run($sformatf("ERR out_row=%0h out_col=%0h expected %0h %0h",
				out_row, out_col, exp_row, exp_col));
			for (int ch = 0; ch < OUT_CH; ch++)
				assert (out_data[ch] == expected_result(exp_row, exp_col, ch))
				else abort_run($sformatf("ERR out_data[%0d]=%0h expected %0h at row %0h col %0h",
					ch, out_data[ch], expected_result(exp_row, exp_col, ch), exp_row, exp_col));
			assert (done == (exp_row == OUT_H - 1 && exp_col == OUT_W - 1))
			else abort_run($sformatf("ERR done=%0h at row %0h col %0h", done, exp_row, exp_col));
			if (exp_col == OUT_W - 1)
			begin
				exp_col = 0;
				if (exp_row == OUT_H - 1)
				begin
					exp_row = 0;
					runs_done++;
				end
				else
					exp_row++;
			end
			else
				exp_col++;
		end
		else
			assert (!done)
			else abort_run($sformatf("ERR done=%0h with out_valid=%0h", done, out_valid));
	end

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		fill_memory();
		repeat (8) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		for (int run = 0; run < 2; run++)
		begin
			// second run sees fresh contents
			if (run > 0)
				fill_memory();
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			do
				@(negedge clk);
			while (!done);
			repeat (4) @(negedge clk);
		end
		if (runs_done == 2)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
			abort_run($sformatf("only %0d of 2 runs finished", runs_done));
	end

endmodule

// ==== project.f ====
hdl/conv_pkg.sv
hdl/mem_map_pkg.sv
hdl/mem_wb_if.sv
hdl/mem_arbiter.sv
hdl/coef_loader.sv
hdl/pixel_fetcher.sv
hdl/line_window.sv
hdl/conv_mac.sv
hdl/conv_layer_top.sv
testbench/tb_mem_model.sv
testbench/tb_conv_layer.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_conv_layer -f project.f --Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
